//--- alu.sv
module alu (
	input  rf_datapath_pkg::alu_op_e           op,
	input  logic [rf_datapath_pkg::data_w-1:0] a,
	input  logic [rf_datapath_pkg::data_w-1:0] b,
	output logic [rf_datapath_pkg::data_w-1:0] y
);
	import rf_datapath_pkg::*;

	logic signed_lt;

	// Signed compare for SLT and SLTI
	assign signed_lt = $signed(a) < $signed(b);

	always_comb begin
		case (op)
			// Wrapping, no overflow trap
			alu_add: y = a + b;
			alu_sub: y = a - b;
			alu_and: y = a & b;
			alu_or:  y = a | b;
			alu_xor: y = a ^ b;
			alu_nor: y = ~(a | b);
			alu_slt: y = {{(data_w - 1){1'b0}}, signed_lt};
			// Immediate into the upper half, low half cleared
			alu_lui: y = {b[imm_w-1:0], {(data_w - imm_w){1'b0}}};
			default: y = '0;
		endcase
	end

endmodule

//--- exec_stage.sv
module exec_stage (
	input  logic                                   clk,
	input  logic                                   rst_n,
	input  logic                                   in_valid,
	output logic                                   in_ready,
	dec_if.exec                                    dec,
	input  logic [rf_datapath_pkg::data_w-1:0]     op_a,
	input  logic [rf_datapath_pkg::data_w-1:0]     op_b,
	fwd_if.exec                                    fwd,
	output logic                                   write_enable,
	output logic [rf_datapath_pkg::reg_addr_w-1:0] write_addr,
	output logic [rf_datapath_pkg::data_w-1:0]     write_data,
	output logic                                   out_valid,
	input  logic                                   out_ready,
	output logic                                   out_write,
	output logic [rf_datapath_pkg::reg_addr_w-1:0] out_addr,
	output logic [rf_datapath_pkg::data_w-1:0]     out_data
);
	import rf_datapath_pkg::*;

	logic                  stall;
	logic                  advance;
	logic                  accept;
	// Execute register
	logic                  ex_valid;
	logic                  ex_writes;
	logic [reg_addr_w-1:0] ex_dest;
	alu_op_e               ex_op;
	logic [data_w-1:0]     ex_a;
	logic [data_w-1:0]     ex_b;
	logic [data_w-1:0]     ex_result;

	//////////////////////////////////////////////////////////////////////
	// Handshake
	//////////////////////////////////////////////////////////////////////

	// Held result beat freezes both stages
	assign stall    = out_valid && !out_ready;
	assign advance  = !stall;
	assign in_ready = advance;
	assign accept   = in_valid && advance;

	// Valid bits move together on every advance
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ex_valid  <= 1'b0;
			out_valid <= 1'b0;
		end else if (advance) begin
			ex_valid  <= in_valid;
			out_valid <= ex_valid;
		end
	end

	// Execute payload, loaded only on acceptance
	always_ff @(posedge clk) begin
		if (accept) begin
			ex_a      <= op_a;
			ex_b      <= op_b;
			ex_op     <= dec.alu_op;
			ex_dest   <= dec.dest_addr;
			ex_writes <= dec.writes_reg;
		end
	end

	alu alu_i (
		.op (ex_op),
		.a  (ex_a),
		.b  (ex_b),
		.y  (ex_result)
	);

	// Writeback payload, this is the out port
	always_ff @(posedge clk) begin
		if (advance && ex_valid) begin
			out_write <= ex_writes;
			out_addr  <= ex_dest;
			out_data  <= ex_result;
		end
	end

	// Register write on the edge that moves the beat into writeback
	assign write_enable = ex_valid && ex_writes && advance;
	assign write_addr   = ex_dest;
	assign write_data   = ex_result;

	// Execute contents back to the forwarding mux
	assign fwd.ex_valid  = ex_valid;
	assign fwd.ex_writes = ex_writes;
	assign fwd.ex_dest   = ex_dest;
	assign fwd.ex_result = ex_result;

endmodule

//--- instr_decoder.sv
module instr_decoder (
	input  logic [rf_datapath_pkg::data_w-1:0] instr,
	dec_if.decoder                             dec
);
	import rf_datapath_pkg::*;

	opcode_e               opcode;
	funct_e                funct;
	logic [imm_w-1:0]      imm16;
	logic [data_w-1:0]     imm_sext;
	logic [data_w-1:0]     imm_zext;
	logic [reg_addr_w-1:0] dest;
	logic                  legal;

	// Raw fields
	assign opcode = opcode_e'(instr[op_hi:op_lo]);
	assign funct  = funct_e'(instr[funct_hi:funct_lo]);
	assign imm16  = instr[imm_hi:imm_lo];

	// Both extensions, chosen per opcode below
	assign imm_sext = {{(data_w - imm_w){imm16[imm_w-1]}}, imm16};
	assign imm_zext = {{(data_w - imm_w){1'b0}}, imm16};

	// Source registers always come from rs and rt
	assign dec.rs_addr = instr[rs_hi:rs_lo];
	assign dec.rt_addr = instr[rt_hi:rt_lo];

	always_comb begin
		// I-type defaults, rt is the destination
		legal       = 1'b1;
		dec.alu_op  = alu_add;
		dec.use_imm = 1'b1;
		dec.imm     = imm_sext;
		dest        = instr[rt_hi:rt_lo];
		case (opcode)
			op_rtype: begin
				dec.use_imm = 1'b0;
				dest        = instr[rd_hi:rd_lo];
				case (funct)
					fn_addu: dec.alu_op = alu_add;
					fn_subu: dec.alu_op = alu_sub;
					fn_and:  dec.alu_op = alu_and;
					fn_or:   dec.alu_op = alu_or;
					fn_xor:  dec.alu_op = alu_xor;
					fn_nor:  dec.alu_op = alu_nor;
					fn_slt:  dec.alu_op = alu_slt;
					default: legal = 1'b0;
				endcase
			end
			// Arithmetic forms sign-extend
			op_addiu: dec.alu_op = alu_add;
			op_slti:  dec.alu_op = alu_slt;
			// Logical forms zero-extend
			op_andi: begin
				dec.alu_op = alu_and;
				dec.imm    = imm_zext;
			end
			op_ori: begin
				dec.alu_op = alu_or;
				dec.imm    = imm_zext;
			end
			op_xori: begin
				dec.alu_op = alu_xor;
				dec.imm    = imm_zext;
			end
			// ALU shifts the low half up
			op_lui: begin
				dec.alu_op = alu_lui;
				dec.imm    = imm_zext;
			end
			// Anything else retires as a no-op
			default: legal = 1'b0;
		endcase
	end

	assign dec.dest_addr  = dest;
	assign dec.writes_reg = legal && (dest != '0);

endmodule

//--- operand_forward.sv
module operand_forward (
	dec_if.forward                             dec,
	fwd_if.forward                             fwd,
	input  logic [rf_datapath_pkg::data_w-1:0] rf_a,
	input  logic [rf_datapath_pkg::data_w-1:0] rf_b,
	output logic [rf_datapath_pkg::data_w-1:0] op_a,
	output logic [rf_datapath_pkg::data_w-1:0] op_b
);
	import rf_datapath_pkg::*;

	logic ex_live;
	logic hit_a;
	logic hit_b;

	// Instruction ahead is still in execute and will write
	assign ex_live = fwd.ex_valid && fwd.ex_writes;

	// Match on a real register only, $0 never forwards
	assign hit_a = ex_live && (dec.rs_addr != '0) && (fwd.ex_dest == dec.rs_addr);
	assign hit_b = ex_live && (dec.rt_addr != '0) && (fwd.ex_dest == dec.rt_addr);

	assign op_a = hit_a ? fwd.ex_result : rf_a;

	// Immediate forms ignore rt as a source
	always_comb begin
		if (dec.use_imm)
			op_b = dec.imm;
		else if (hit_b)
			op_b = fwd.ex_result;
		else
			op_b = rf_b;
	end

endmodule

//--- reg_file.sv
module reg_file (
	input  logic                                  clk,
	input  logic                                  rst_n,
	input  logic [rf_datapath_pkg::reg_addr_w-1:0] raddr1,
	input  logic [rf_datapath_pkg::reg_addr_w-1:0] raddr2,
	output logic [rf_datapath_pkg::data_w-1:0]     rdata1,
	output logic [rf_datapath_pkg::data_w-1:0]     rdata2,
	input  logic                                  write_enable,
	input  logic [rf_datapath_pkg::reg_addr_w-1:0] write_addr,
	input  logic [rf_datapath_pkg::data_w-1:0]     write_data
);
	import rf_datapath_pkg::*;

	// Only $1..$31 have storage
	logic [data_w-1:0] regs [1:num_regs-1];
	logic              wr_live;

	// Writes to $0 are dropped here
	assign wr_live = write_enable && (write_addr != '0);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 1; i < num_regs; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_live) begin
			regs[write_addr] <= write_data;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Read ports
	//////////////////////////////////////////////////////////////////////

	// Port 1, $0 reads zero, same-cycle write is bypassed
	always_comb begin
		if (raddr1 == '0)
			rdata1 = '0;
		else if (wr_live && (write_addr == raddr1))
			rdata1 = write_data;
		else
			rdata1 = regs[raddr1];
	end

	// Port 2, same rules
	always_comb begin
		if (raddr2 == '0)
			rdata2 = '0;
		else if (wr_live && (write_addr == raddr2))
			rdata2 = write_data;
		else
			rdata2 = regs[raddr2];
	end

endmodule

//--- rf_datapath.f
rf_datapath_pkg.sv
rf_datapath_if.sv
reg_file.sv
instr_decoder.sv
operand_forward.sv
alu.sv
exec_stage.sv
rf_datapath.sv
tb_result_checker.sv
tb_rf_datapath.sv

//--- rf_datapath.sv
module rf_datapath (
	input  logic                                   clk,
	input  logic                                   rst_n,
	// Instruction stream
	input  logic                                   in_valid,
	output logic                                   in_ready,
	input  logic [rf_datapath_pkg::data_w-1:0]     in_instr,
	// Retired instruction stream
	output logic                                   out_valid,
	input  logic                                   out_ready,
	output logic                                   out_write,
	output logic [rf_datapath_pkg::reg_addr_w-1:0] out_addr,
	output logic [rf_datapath_pkg::data_w-1:0]     out_data
);
	import rf_datapath_pkg::*;

	logic [data_w-1:0]     rf_a;
	logic [data_w-1:0]     rf_b;
	logic [data_w-1:0]     op_a;
	logic [data_w-1:0]     op_b;
	logic                  write_enable;
	logic [reg_addr_w-1:0] write_addr;
	logic [data_w-1:0]     write_data;

	dec_if dec ();
	fwd_if fwd ();

	instr_decoder decoder_i (
		.instr (in_instr),
		.dec   (dec.decoder)
	);

	// Read addresses straight from decode
	reg_file reg_file_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.raddr1       (dec.rs_addr),
		.raddr2       (dec.rt_addr),
		.rdata1       (rf_a),
		.rdata2       (rf_b),
		.write_enable (write_enable),
		.write_addr   (write_addr),
		.write_data   (write_data)
	);

	operand_forward forward_i (
		.dec  (dec.forward),
		.fwd  (fwd.forward),
		.rf_a (rf_a),
		.rf_b (rf_b),
		.op_a (op_a),
		.op_b (op_b)
	);

	exec_stage exec_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.in_valid     (in_valid),
		.in_ready     (in_ready),
		.dec          (dec.exec),
		.op_a         (op_a),
		.op_b         (op_b),
		.fwd          (fwd.exec),
		.write_enable (write_enable),
		.write_addr   (write_addr),
		.write_data   (write_data),
		.out_valid    (out_valid),
		.out_ready    (out_ready),
		.out_write    (out_write),
		.out_addr     (out_addr),
		.out_data     (out_data)
	);

endmodule

//--- rf_datapath_if.sv
// Decoded instruction, fanned out to forwarding and execute
interface dec_if;
	import rf_datapath_pkg::*;

	logic [reg_addr_w-1:0] rs_addr;
	logic [reg_addr_w-1:0] rt_addr;
	logic [reg_addr_w-1:0] dest_addr;
	// Already extended to full width
	logic [data_w-1:0]     imm;
	logic                  use_imm;
	alu_op_e               alu_op;
	// Low for illegal codes and for $0
	logic                  writes_reg;

	modport decoder (output rs_addr, rt_addr, dest_addr, imm, use_imm, alu_op, writes_reg);
	modport forward (input rs_addr, rt_addr, dest_addr, imm, use_imm, alu_op, writes_reg);
	modport exec    (input rs_addr, rt_addr, dest_addr, imm, use_imm, alu_op, writes_reg);
endinterface

// Execute stage contents seen by the forwarding mux
interface fwd_if;
	import rf_datapath_pkg::*;

	logic                  ex_valid;
	logic                  ex_writes;
	logic [reg_addr_w-1:0] ex_dest;
	logic [data_w-1:0]     ex_result;

	modport exec    (output ex_valid, ex_writes, ex_dest, ex_result);
	modport forward (input ex_valid, ex_writes, ex_dest, ex_result);
endinterface

//--- rf_datapath_pkg.sv
package rf_datapath_pkg;

	//////////////////////////////////////////////////////////////////////
	// Datapath widths
	//////////////////////////////////////////////////////////////////////

	localparam int data_w     = 32;
	localparam int reg_addr_w = 5;
	localparam int num_regs   = 32;

	//////////////////////////////////////////////////////////////////////
	// Instruction fields
	//////////////////////////////////////////////////////////////////////

	localparam int op_hi    = 31;
	localparam int op_lo    = 26;
	localparam int rs_hi    = 25;
	localparam int rs_lo    = 21;
	localparam int rt_hi    = 20;
	localparam int rt_lo    = 16;
	localparam int rd_hi    = 15;
	localparam int rd_lo    = 11;
	localparam int funct_hi = 5;
	localparam int funct_lo = 0;
	localparam int imm_hi   = 15;
	localparam int imm_lo   = 0;
	// Immediate field width, used for extension and LUI
	localparam int imm_w    = imm_hi - imm_lo + 1;

	// Major opcodes, MIPS encodings
	typedef enum logic [5:0] {
		op_rtype = 6'd0,
		op_addiu = 6'd9,
		op_slti  = 6'd10,
		op_andi  = 6'd12,
		op_ori   = 6'd13,
		op_xori  = 6'd14,
		op_lui   = 6'd15
	} opcode_e;

	// R-type function codes
	typedef enum logic [5:0] {
		fn_addu = 6'd33,
		fn_subu = 6'd35,
		fn_and  = 6'd36,
		fn_or   = 6'd37,
		fn_xor  = 6'd38,
		fn_nor  = 6'd39,
		fn_slt  = 6'd42
	} funct_e;

	// Internal ALU operation, decoupled from the instruction encoding
	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_nor,
		alu_slt,
		alu_lui
	} alu_op_e;

endpackage

//--- rf_datapath_trace.txt
# instr write dest data, all hex, one instruction per line in issue order
# dest and data are compared only when write is 1
# Operand setup with LUI and ORI, back-to-back dependence
3c018000 1 01 80000000
34210005 1 01 80000005
34020007 1 02 00000007
# R-type operations
00221821 1 03 8000000c
00412023 1 04 80000002
00232824 1 05 80000004
00433025 1 06 8000000f
00223826 1 07 80000002
00404027 1 08 fffffff8
0022482a 1 09 00000001
0101502a 1 0a 00000000
0028582a 1 0b 00000001
# Immediate forms
244cfff0 1 0c fffffff7
284dffff 1 0d 00000000
298efff8 1 0e 00000001
310fff0f 1 0f 0000ff08
34308000 1 10 80008005
39118001 1 11 ffff7ff9
3c121234 1 12 12340000
# Register 0
00220021 0 00 00000000
00009821 1 13 00000000
0000c827 1 19 ffffffff
# Illegal encodings, no write
fc21ffff 0 00 00000000
00221000 0 00 00000000
8c230000 0 00 00000000
# Reads after the illegal encodings
0020a025 1 14 80000005
0043a821 1 15 80000013
0040d025 1 1a 00000007
0060d825 1 1b 8000000c
# Dependence chain at distances one and two
26b60001 1 16 80000014
02d5b823 1 17 00000001
02f6b021 1 16 80000015
02d7c026 1 18 80000014

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the rf_datapath testbench with Verilator
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary -f rf_datapath.f --top-module tb_rf_datapath -o tb_rf_datapath \
	|| { echo "Verilator build failed"; exit 1; }

./obj_dir/tb_rf_datapath > "$log" 2>&1
run_status=$?
cat "$log"

# Fail on a crashed run or on the fail message in the log
[ "$run_status" -eq 0 ] && ! grep -q "RESULT: FAIL" "$log" \
	&& { echo "Simulation passed"; exit 0; } \
	|| { echo "Simulation failed"; exit 1; }

//--- tb_result_checker.sv
module tb_result_checker (
	input  logic                                   clk,
	input  logic                                   rst_n,
	input  logic                                   out_valid,
	input  logic                                   out_ready,
	input  logic                                   out_write,
	input  logic [rf_datapath_pkg::reg_addr_w-1:0] out_addr,
	input  logic [rf_datapath_pkg::data_w-1:0]     out_data,
	output int                                     retired,
	output int                                     errors
);
	import rf_datapath_pkg::*;

	// Expected beats in retirement order
	logic                  exp_write [$];
	logic [reg_addr_w-1:0] exp_addr  [$];
	logic [data_w-1:0]     exp_data  [$];

	// Filled by the testbench top while it reads the trace
	task automatic add_expect(
		input logic                  w,
		input logic [reg_addr_w-1:0] a,
		input logic [data_w-1:0]     d
	);
		exp_write.push_back(w);
		exp_addr.push_back(a);
		exp_data.push_back(d);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Result port monitor
	//////////////////////////////////////////////////////////////////////

	// Sampled at the edge that moves the beat
	always @(posedge clk or negedge rst_n) begin : check_beat
		logic                  w;
		logic [reg_addr_w-1:0] a;
		logic [data_w-1:0]     d;
		if (!rst_n) begin
			retired <= 0;
			errors  <= 0;
		end else if (out_valid && out_ready) begin
			if (exp_write.size() == 0) begin
				errors <= errors + 1;
				$display(
					"Result arrived with no expectation left at %0t (write=%0b addr=%0d data=%h)",
					$time, out_write, out_addr, out_data);
			end else begin
				w = exp_write.pop_front();
				a = exp_addr.pop_front();
				d = exp_data.pop_front();
				retired <= retired + 1;
				// Address and data only matter for a writing instruction
				if (out_write !== w || (w && (out_addr !== a || out_data !== d))) begin
					errors <= errors + 1;
					$display("[FAIL] %0t instr %0d got %0b %0d %h, expected %0b %0d %h",
						$time, retired, out_write, out_addr, out_data, w, a, d);
				end else begin
					$display("[PASS] instr %0d write=%0b addr=%0d data=%h",
						retired, out_write, out_addr, out_data);
				end
			end
		end
	end

endmodule

//--- tb_rf_datapath.sv
module tb_rf_datapath;
	import rf_datapath_pkg::*;

	localparam int    clk_period       = 10;
	localparam int    reset_cycles     = 5;
	// Watchdog budget per instruction
	localparam int    cycles_per_instr = 20;
	localparam int    rand_seed        = 32'h6e9f29dd;
	localparam string trace_file       = "rf_datapath_trace.txt";

	logic                  clk = 1'b0;
	logic                  rst_n;
	logic                  in_valid;
	logic                  in_ready;
	logic [data_w-1:0]     in_instr;
	logic                  out_valid;
	logic                  out_ready;
	logic                  out_write;
	logic [reg_addr_w-1:0] out_addr;
	logic [data_w-1:0]     out_data;
	int                    retired;
	int                    errors;

	// Instruction words from the trace
	logic [data_w-1:0]     instr_q [$];
	int                    n_instr      = 0;
	bit                    trace_loaded = 1'b0;
	bit                    loaded_ok;

	always #(clk_period / 2) clk = ~clk;

	rf_datapath dut_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in_instr  (in_instr),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_write (out_write),
		.out_addr  (out_addr),
		.out_data  (out_data)
	);

	tb_result_checker checker_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_write (out_write),
		.out_addr  (out_addr),
		.out_data  (out_data),
		.retired   (retired),
		.errors    (errors)
	);

	//////////////////////////////////////////////////////////////////////
	// Trace reader
	//////////////////////////////////////////////////////////////////////

	task automatic load_trace(output bit ok);
		int          fd;
		int          code;
		bit          bad;
		string       line;
		logic [31:0] f_instr;
		logic [31:0] f_write;
		logic [31:0] f_addr;
		logic [31:0] f_data;
		ok  = 1'b0;
		bad = 1'b0;
		fd  = $fopen(trace_file, "r");
		if (fd == 0)
			return;
		while ($fgets(line, fd) != 0) begin
			// Comment lines carry no instruction
			if (line.len() == 0 || line.getc(0) == "#")
				continue;
			code = $sscanf(line, "%h %h %h %h", f_instr, f_write, f_addr, f_data);
			if (code == 4) begin
				instr_q.push_back(f_instr);
				checker_i.add_expect(f_write[0], f_addr[reg_addr_w-1:0], f_data);
			end else if (code > 0) begin
				$display("Malformed trace line: %s", line);
				bad = 1'b1;
			end
		end
		$fclose(fd);
		n_instr = instr_q.size();
		ok      = (n_instr > 0) && !bad;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////////////////////////

	// Starts and ends on a falling edge
	task automatic drive_instrs();
		for (int i = 0; i < n_instr; i++) begin
			// Random idle gap with garbage on the bus
			while (($urandom % 4) == 0) begin
				in_valid = 1'b0;
				in_instr = $urandom;
				@(negedge clk);
			end
			in_valid = 1'b1;
			in_instr = instr_q[i];
			// Hold the beat until an edge with ready high
			do begin
				@(posedge clk);
			end while (!in_ready);
			@(negedge clk);
		end
		in_valid = 1'b0;
		in_instr = '0;
	endtask

	// Random back-pressure on the result port
	initial begin
		out_ready = 1'b1;
		wait (rst_n);
		forever begin
			@(negedge clk);
			out_ready = ($urandom % 4) != 0;
		end
	end

	initial begin
		void'($urandom(rand_seed));
		rst_n    = 1'b0;
		in_valid = 1'b0;
		in_instr = '0;
		load_trace(loaded_ok);
		if (!loaded_ok) begin
			$display("Could not read a usable instruction list from %s", trace_file);
			$display("RESULT: FAIL");
			$finish;
		end else begin
			trace_loaded = 1'b1;
			repeat (reset_cycles) @(posedge clk);
			@(negedge clk);
			rst_n = 1'b1;
			drive_instrs();
			wait (retired == n_instr);
			// Drain window so surplus beats get caught
			repeat (cycles_per_instr) @(posedge clk);
			@(negedge clk);
			$display("Retired %0d of %0d instructions, %0d errors", retired, n_instr, errors);
			if (errors == 0)
				$display("RESULT: PASS");
			else
				$display("RESULT: FAIL");
			$finish;
		end
	end

	// Watchdog sized from the trace length
	initial begin
		wait (trace_loaded);
		#((n_instr * cycles_per_instr + reset_cycles) * clk_period);
		$display("Timeout with %0d of %0d instructions retired", retired, n_instr);
		$display("RESULT: FAIL");
		$finish;
	end

endmodule
